// ==== Makefile ====
VERILATOR  := verilator
TOP        := tb_spw_tx
RTL_TOP    := spw_tx_top
FILELIST   := list.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== include/spw_tx_params.svh ====
// Link constants for the SpaceWire transmitter
// The batch size must fit the 3-bit FCT count of spw_tx_pkg
`ifndef SPW_TX_PARAMS_SVH
`define SPW_TX_PARAMS_SVH

// --------------------
// Flow control
// --------------------
// Requests per batch, also the ceiling on pending FCTs
`define SPW_FCT_BATCH 7
// Credit owed to the peer right after reset
`define SPW_RESET_CREDIT 7

// --------------------
// Character lengths in bits, parity and flag included
// --------------------
`define SPW_CTRL_LEN 4
`define SPW_DATA_LEN 10

`endif

// ==== list.f ====
+incdir+include
source/spw_tx_pkg.sv
source/tx_char_if.sv
source/tx_fct_send.sv
source/tx_control.sv
source/tx_char_encoder.sv
source/tx_ds_serializer.sv
source/spw_tx_top.sv
test/tb_spw_tx.sv

// ==== source/spw_tx_pkg.sv ====
// Shared types of the SpaceWire transmitter
// Vector widths are fixed and must agree with spw_tx_params.svh
`default_nettype none

package spw_tx_pkg;

	// --------------------
	// Vector types
	// --------------------
	// FCT count, both for the batch and for the pending credit
	typedef logic [2:0] fct_count_t;
	// One N-char payload byte
	typedef logic [7:0] spw_byte_t;
	// Code word, LSB goes out first, unused high bits zero
	typedef logic [9:0] spw_code_t;
	// Length of a character in bits
	typedef logic [3:0] code_len_t;

	// --------------------
	// Enums
	// --------------------
	// Kind of character chosen for a slot
	typedef enum logic [1:0] {CHAR_FCT, CHAR_ESC, CHAR_DATA} char_kind_t;

	// Drain FSM of the FCT bookkeeping
	typedef enum logic [1:0] {FCT_COLLECT, FCT_SENDING, FCT_WAIT_LOW} fct_state_t;

	// Slot FSM, second state finishes a NULL
	typedef enum logic {CTRL_CHOOSE, CTRL_NULL_TAIL} ctrl_state_t;

endpackage

`default_nettype wire

// ==== source/spw_tx_top.sv ====
// SpaceWire character transmitter, single clock domain
// No EOP/EEP, time codes or link init FSM
`default_nettype none

module spw_tx_top (
	input wire logic pclk_tx,
	input wire logic enable_tx,
	input wire logic send_fct_now,
	input wire logic tx_write,
	input wire spw_tx_pkg::spw_byte_t tx_data,
	output logic tx_ready,
	output logic d,
	output logic s
);
	import spw_tx_pkg::*;

	fct_count_t fct_flag_p;
	logic fct_sent;

	// Character path control -> encoder -> serializer
	tx_char_if chr ();

	// FCT credit
	tx_fct_send fct_send_i (
		.pclk_tx(pclk_tx),
		.enable_tx(enable_tx),
		.send_fct_now(send_fct_now),
		.fct_sent(fct_sent),
		.fct_flag_p(fct_flag_p)
	);

	tx_control control_i (
		.pclk_tx(pclk_tx),
		.enable_tx(enable_tx),
		.tx_write(tx_write),
		.tx_data(tx_data),
		.fct_flag_p(fct_flag_p),
		.tx_ready(tx_ready),
		.fct_sent(fct_sent),
		.chr(chr.ctrl)
	);

	tx_char_encoder encoder_i (
		.pclk_tx(pclk_tx),
		.enable_tx(enable_tx),
		.chr(chr.enc)
	);

	// Line drivers
	tx_ds_serializer serializer_i (
		.pclk_tx(pclk_tx),
		.enable_tx(enable_tx),
		.d(d),
		.s(s),
		.chr(chr.ser)
	);

endmodule

`default_nettype wire

// ==== source/tx_char_encoder.sv ====
// Code word builder with parity carried across characters
// Parity register follows only characters actually taken
`default_nettype none

`include "spw_tx_params.svh"

module tx_char_encoder (
	input wire logic pclk_tx,
	input wire logic enable_tx,
	tx_char_if.enc chr
);
	import spw_tx_pkg::*;

	localparam int PAD_LEN = `SPW_DATA_LEN - `SPW_CTRL_LEN;

	// XOR of the previous character's payload bits
	logic par_q;
	logic flag;
	logic par_bit;
	logic payload_par;
	logic [1:0] ctrl_bits;

	always_comb
	begin
		flag = (chr.kind != CHAR_DATA);
		// FCT is 00, ESC is 11
		ctrl_bits = (chr.kind == CHAR_ESC) ? 2'b11 : 2'b00;
		payload_par = flag ? ^ctrl_bits : ^chr.data;
		// Odd over previous payload, this parity and this flag
		par_bit = ~(par_q ^ flag);
		if (flag)
		begin
			chr.code = {{PAD_LEN{1'b0}}, ctrl_bits, 1'b1, par_bit};
			chr.code_len = code_len_t'(`SPW_CTRL_LEN);
		end
		else
		begin
			chr.code = {chr.data, 1'b0, par_bit};
			chr.code_len = code_len_t'(`SPW_DATA_LEN);
		end
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
			par_q <= 1'b0;
		else if (chr.take)
			par_q <= payload_par;
	end

endmodule

`default_nettype wire

// ==== source/tx_char_if.sv ====
// One character from control through encoder to serializer
// Transfer happens only in a cycle with take high
`default_nettype none

interface tx_char_if;
	import spw_tx_pkg::*;

	// Serializer wants a character for the next edge
	logic need;
	// Character moves on this edge
	logic take;
	char_kind_t kind;
	spw_byte_t data;
	// Encoded word and its bit count
	spw_code_t code;
	code_len_t code_len;

	// Chooses the character
	modport ctrl (input need, output take, kind, data);
	// Encodes it, parity tracked on take
	modport enc (input take, kind, data, output code, code_len);
	// Puts it on the line
	modport ser (input take, code, code_len, output need);

endinterface

`default_nettype wire

// ==== source/tx_control.sv ====
// Slot scheduler, FCT first, then held byte, else NULL
// Holds a single byte; writes while tx_ready is low are dropped
`default_nettype none

module tx_control (
	input wire logic pclk_tx,
	input wire logic enable_tx,
	input wire logic tx_write,
	input wire spw_tx_pkg::spw_byte_t tx_data,
	input wire spw_tx_pkg::fct_count_t fct_flag_p,
	output logic tx_ready,
	output logic fct_sent,
	tx_char_if.ctrl chr
);
	import spw_tx_pkg::*;

	ctrl_state_t state;
	spw_byte_t data_q;
	logic full;
	logic accept;
	logic data_take;
	logic full_next;

	// --------------------
	// Slot choice
	// --------------------
	always_comb
	begin
		chr.take = chr.need && enable_tx;
		fct_sent = 1'b0;
		if (state == CTRL_NULL_TAIL)
		begin
			// Tail of a NULL, owes no credit
			chr.kind = CHAR_FCT;
		end
		else if (fct_flag_p != '0)
		begin
			chr.kind = CHAR_FCT;
			fct_sent = chr.take;
		end
		else if (full)
		begin
			chr.kind = CHAR_DATA;
		end
		else
		begin
			chr.kind = CHAR_ESC;
		end
	end

	assign chr.data = data_q;

	assign accept = tx_write && tx_ready;
	assign data_take = chr.take && (chr.kind == CHAR_DATA);
	assign full_next = (full && !data_take) || accept;

	// Held byte, only valid while full
	always_ff @(posedge pclk_tx)
	begin
		if (accept)
		begin
			data_q <= tx_data;
		end
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			state <= CTRL_CHOOSE;
			full <= 1'b0;
			tx_ready <= 1'b0;
		end
		else
		begin
			full <= full_next;
			tx_ready <= !full_next;
			if (chr.take)
			begin
				// ESC always followed by FCT
				state <= (chr.kind == CHAR_ESC) ? CTRL_NULL_TAIL : CTRL_CHOOSE;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/tx_ds_serializer.sv ====
// Data-strobe output stage, one bit per clock, LSB first
// Expects a new character on the edge after its last bit
`default_nettype none

module tx_ds_serializer (
	input wire logic pclk_tx,
	input wire logic enable_tx,
	output logic d,
	output logic s,
	tx_char_if.ser chr
);
	import spw_tx_pkg::*;

	// Bits still to go out, current one excluded
	spw_code_t sh_q;
	// Bits on and behind the line, current one included
	code_len_t bits_left;
	logic step;
	logic d_next;

	// Last bit on the line, or idle
	assign chr.need = (bits_left <= code_len_t'(1));

	assign step = chr.take || (bits_left > code_len_t'(1));
	assign d_next = chr.take ? chr.code[0] : sh_q[0];

	// --------------------
	// Shift register
	// --------------------
	always_ff @(posedge pclk_tx)
	begin
		if (chr.take)
			sh_q <= chr.code >> 1;
		else if (step)
			sh_q <= sh_q >> 1;
	end

	// --------------------
	// Line stage
	// --------------------
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			d <= 1'b0;
			s <= 1'b0;
			bits_left <= '0;
		end
		else if (step)
		begin
			d <= d_next;
			// Strobe toggles when data holds
			s <= s ^ (d_next == d);
			bits_left <= chr.take ? chr.code_len : bits_left - code_len_t'(1);
		end
		else if (bits_left != '0)
		begin
			// Nothing followed, line holds its level
			bits_left <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== source/tx_fct_send.sv ====
// FCT credit bookkeeping, pending count starts at the reset credit
// fct_sent is expected as a single-cycle pulse per FCT sent
`default_nettype none

`include "spw_tx_params.svh"

module tx_fct_send (
	input wire logic pclk_tx,
	input wire logic enable_tx,
	input wire logic send_fct_now,
	input wire logic fct_sent,
	output spw_tx_pkg::fct_count_t fct_flag_p
);
	import spw_tx_pkg::*;

	localparam fct_count_t BATCH_FULL = fct_count_t'(`SPW_FCT_BATCH);
	localparam fct_count_t RESET_CREDIT = fct_count_t'(`SPW_RESET_CREDIT);

	fct_state_t state;
	fct_count_t fct_batch;
	logic load_batch;

	// Full batch and nothing owed, hand batch over
	assign load_batch = (state == FCT_COLLECT) && (fct_batch == BATCH_FULL) &&
		(fct_flag_p == '0);

	// --------------------
	// Request batching
	// --------------------
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			fct_batch <= '0;
		end
		else if (load_batch)
		begin
			// Request in the hand-over cycle opens the next batch
			fct_batch <= send_fct_now ? fct_count_t'(1) : '0;
		end
		else if (send_fct_now && (fct_batch != BATCH_FULL))
		begin
			fct_batch <= fct_batch + fct_count_t'(1);
		end
	end

	// --------------------
	// Drain FSM
	// --------------------
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			// Reset credit is owed straight away
			fct_flag_p <= RESET_CREDIT;
			state <= FCT_SENDING;
		end
		else
		begin
			case (state)
			FCT_COLLECT:
			begin
				if (load_batch)
				begin
					fct_flag_p <= fct_batch;
					state <= FCT_SENDING;
				end
			end
			FCT_SENDING:
			begin
				if (fct_sent && (fct_flag_p != '0))
				begin
					fct_flag_p <= fct_flag_p - fct_count_t'(1);
					state <= FCT_WAIT_LOW;
				end
			end
			FCT_WAIT_LOW:
			begin
				// Let the pulse drop before counting again
				if (!fct_sent)
				begin
					state <= (fct_flag_p == '0) ? FCT_COLLECT : FCT_SENDING;
				end
			end
			default:
			begin
				state <= FCT_COLLECT;
			end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== test/tb_spw_tx.sv ====
// Directed testbench for the SpaceWire transmitter, d/s decoded back into characters
// Assumes a gapless line from the second edge after reset release
`default_nettype none

`include "spw_tx_params.svh"

module tb_spw_tx;
	import spw_tx_pkg::*;

	localparam fct_count_t BATCH_FULL = fct_count_t'(`SPW_FCT_BATCH);
	localparam fct_count_t RESET_CREDIT = fct_count_t'(`SPW_RESET_CREDIT);
	localparam int NUM_BYTES = 8;
	// Rough length of each test in clock cycles
	localparam int LEN_IDLE = 150;
	localparam int LEN_DATA = 300;
	localparam int LEN_BATCH = 250;
	localparam int LEN_SAT = 150;
	localparam int LEN_CODING = 200;
	localparam int LEN_DROP = 150;
	localparam int LEN_MARGIN = 200;
	localparam int WATCHDOG_CYCLES = LEN_IDLE + LEN_DATA + LEN_BATCH + LEN_SAT +
		LEN_CODING + LEN_DROP + LEN_MARGIN;

	logic pclk_tx;
	logic enable_tx;
	logic send_fct_now;
	logic tx_write;
	spw_byte_t tx_data;
	logic tx_ready;
	logic d;
	logic s;

	string test_name;
	int mismatch_errs = 0;
	int line_errs = 0;
	int other_errs = 0;
	int total_errs;

	// Decoded characters, both halves of a NULL included
	char_kind_t rx_kind[$];
	spw_byte_t rx_byte[$];

	// --------------------
	// Line decoder state
	// --------------------
	logic line_on;
	logic prev_d;
	logic prev_s;
	// XOR of the previous payload
	logic prev_pay;
	logic cur_par;
	logic cur_flag;
	// Payload shifted in from the top, LSB first
	spw_byte_t pay;
	int bit_pos;

	spw_tx_top dut_i (
		.pclk_tx(pclk_tx),
		.enable_tx(enable_tx),
		.send_fct_now(send_fct_now),
		.tx_write(tx_write),
		.tx_data(tx_data),
		.tx_ready(tx_ready),
		.d(d),
		.s(s)
	);

	always #5 pclk_tx = ~pclk_tx;

	// Monitor, samples the line mid-cycle
	always @(negedge pclk_tx)
	begin
		if (!enable_tx)
		begin
			line_on = 1'b0;
			bit_pos = 0;
			prev_pay = 1'b0;
		end
		else if (!line_on)
		begin
			// Release cycle, first bit comes on the next edge
			line_on = 1'b1;
		end
		else
		begin
			if ((d ^ prev_d) == (s ^ prev_s))
			begin
				line_errs++;
				$display("Error in %s: d and s did not toggle one at a time at %0t",
					test_name, $time);
			end
			if (bit_pos == 0)
				cur_par = d;
			else if (bit_pos == 1)
			begin
				cur_flag = d;
				pay = '0;
			end
			else
				pay = {d, pay[7:1]};
			bit_pos++;
			if (bit_pos == (cur_flag ? `SPW_CTRL_LEN : `SPW_DATA_LEN))
			begin
				// Odd over previous payload, parity and flag
				if ((prev_pay ^ cur_par ^ cur_flag) != 1'b1)
				begin
					line_errs++;
					$display("Error in %s: odd parity broken at %0t", test_name, $time);
				end
				prev_pay = ^pay;
				bit_pos = 0;
				if (!cur_flag)
				begin
					rx_kind.push_back(CHAR_DATA);
					rx_byte.push_back(pay);
				end
				else if (pay[7:6] == 2'b00 || pay[7:6] == 2'b11)
				begin
					rx_kind.push_back((pay[7:6] == 2'b00) ? CHAR_FCT : CHAR_ESC);
					rx_byte.push_back(pay);
				end
				else
				begin
					line_errs++;
					$display("Error in %s: unknown control code at %0t", test_name, $time);
				end
			end
		end
		prev_d = d;
		prev_s = s;
	end

	// Watchdog
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge pclk_tx);
		$display("Error: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

	// --------------------
	// Compare and report
	// --------------------
	task automatic check_kind(input char_kind_t exp, input char_kind_t act);
		if (exp !== act)
		begin
			mismatch_errs++;
			$display("Mismatch in %s: expected %s, actual %s", test_name, exp.name(), act.name());
		end
	endtask

	task automatic check_byte(input spw_byte_t exp, input spw_byte_t act);
		if (exp !== act)
		begin
			mismatch_errs++;
			$display("Mismatch in %s: expected %02h, actual %02h", test_name, exp, act);
		end
	endtask

	task automatic check_count(input fct_count_t exp, input fct_count_t act);
		if (exp !== act)
		begin
			mismatch_errs++;
			$display("Mismatch in %s: expected %0d FCTs, actual %0d", test_name, exp, act);
		end
	endtask

	task automatic note_failure(input string what);
		other_errs++;
		$display("Error in %s: %s", test_name, what);
	endtask

	// --------------------
	// Stimulus and character helpers
	// --------------------
	task automatic apply_reset();
		@(posedge pclk_tx);
		enable_tx <= 1'b0;
		tx_write <= 1'b0;
		send_fct_now <= 1'b0;
		@(posedge pclk_tx);
		@(negedge pclk_tx);
		if (d || s || tx_ready)
			note_failure("d, s or tx_ready not low during reset");
		@(posedge pclk_tx);
		rx_kind.delete();
		rx_byte.delete();
		enable_tx <= 1'b1;
	endtask

	task automatic write_byte(input spw_byte_t b);
		@(negedge pclk_tx);
		while (!tx_ready) @(negedge pclk_tx);
		@(posedge pclk_tx);
		tx_write <= 1'b1;
		tx_data <= b;
		@(posedge pclk_tx);
		tx_write <= 1'b0;
	endtask

	task automatic pulse_fct_request();
		@(posedge pclk_tx);
		send_fct_now <= 1'b1;
		@(posedge pclk_tx);
		send_fct_now <= 1'b0;
	endtask

	task automatic read_char(output char_kind_t k, output spw_byte_t b);
		while (rx_kind.size() == 0) @(posedge pclk_tx);
		k = rx_kind.pop_front();
		b = rx_byte.pop_front();
	endtask

	// One slot, a whole NULL comes back as CHAR_ESC
	task automatic read_slot(output char_kind_t k, output spw_byte_t b);
		char_kind_t tail;
		spw_byte_t tail_b;
		read_char(k, b);
		if (k == CHAR_ESC)
		begin
			read_char(tail, tail_b);
			check_kind(CHAR_FCT, tail);
		end
	endtask

	// Skips up to max_lead NULLs
	task automatic next_non_null(input int max_lead, output char_kind_t k, output spw_byte_t b);
		int lead;
		lead = 0;
		read_slot(k, b);
		while ((k == CHAR_ESC) && (lead < max_lead))
		begin
			lead++;
			read_slot(k, b);
		end
	endtask

	// Standalone FCTs in a row, at most one batch
	task automatic fct_run(input int max_lead, output fct_count_t n);
		char_kind_t k;
		spw_byte_t b;
		n = '0;
		next_non_null(max_lead, k, b);
		while (k == CHAR_FCT)
		begin
			n = n + fct_count_t'(1);
			if (n == BATCH_FULL)
				k = CHAR_ESC;
			else
				read_slot(k, b);
		end
		if (k == CHAR_DATA)
			note_failure("data character inside an FCT run");
	endtask

	task automatic expect_nulls(input int count);
		char_kind_t k;
		spw_byte_t b;
		repeat (count)
		begin
			read_slot(k, b);
			check_kind(CHAR_ESC, k);
		end
	endtask

	// --------------------
	// Tests
	// --------------------
	task automatic reset_credit_and_nulls();
		fct_count_t n;
		test_name = "reset_credit_and_nulls";
		apply_reset();
		fct_run(0, n);
		check_count(RESET_CREDIT, n);
		expect_nulls(8);
	endtask

	task automatic data_order();
		spw_byte_t sent[NUM_BYTES];
		fct_count_t n;
		char_kind_t k;
		spw_byte_t b;
		test_name = "data_order";
		apply_reset();
		for (int i = 0; i < NUM_BYTES; i++)
		begin
			sent[i] = spw_byte_t'($urandom());
			write_byte(sent[i]);
		end
		// Data before the reset credit would break the run
		fct_run(0, n);
		check_count(RESET_CREDIT, n);
		for (int i = 0; i < NUM_BYTES; i++)
		begin
			next_non_null(6, k, b);
			check_kind(CHAR_DATA, k);
			check_byte(sent[i], b);
		end
		expect_nulls(2);
	endtask

	task automatic fct_batching();
		fct_count_t n;
		test_name = "fct_batching";
		apply_reset();
		fct_run(0, n);
		check_count(RESET_CREDIT, n);
		repeat (`SPW_FCT_BATCH - 1) pulse_fct_request();
		expect_nulls(6);
		pulse_fct_request();
		fct_run(2, n);
		check_count(BATCH_FULL, n);
		expect_nulls(3);
	endtask

	task automatic fct_saturation();
		fct_count_t n;
		test_name = "fct_saturation";
		apply_reset();
		// All ten land while the reset credit is still draining
		repeat (10) pulse_fct_request();
		fct_run(0, n);
		check_count(RESET_CREDIT, n);
		fct_run(0, n);
		check_count(BATCH_FULL, n);
		expect_nulls(3);
	endtask

	task automatic line_coding();
		fct_count_t n;
		char_kind_t k;
		spw_byte_t b;
		test_name = "line_coding";
		apply_reset();
		write_byte(8'h00);
		write_byte(8'hff);
		write_byte(8'h80);
		fct_run(0, n);
		check_count(RESET_CREDIT, n);
		next_non_null(4, k, b);
		check_kind(CHAR_DATA, k);
		check_byte(8'h00, b);
		next_non_null(4, k, b);
		check_kind(CHAR_DATA, k);
		check_byte(8'hff, b);
		next_non_null(4, k, b);
		check_kind(CHAR_DATA, k);
		check_byte(8'h80, b);
	endtask

	task automatic dropped_write();
		spw_byte_t held;
		fct_count_t n;
		char_kind_t k;
		spw_byte_t b;
		test_name = "dropped_write";
		held = spw_byte_t'($urandom());
		apply_reset();
		write_byte(held);
		@(negedge pclk_tx);
		if (tx_ready)
			note_failure("tx_ready still high after an accepted write");
		// Second byte differs so a leak shows up
		@(posedge pclk_tx);
		tx_write <= 1'b1;
		tx_data <= ~held;
		@(posedge pclk_tx);
		tx_write <= 1'b0;
		fct_run(0, n);
		check_count(RESET_CREDIT, n);
		next_non_null(4, k, b);
		check_kind(CHAR_DATA, k);
		check_byte(held, b);
		expect_nulls(4);
	endtask

	initial
	begin
		void'($urandom(32'hcfa811a6));
		test_name = "startup";
		pclk_tx = 1'b0;
		enable_tx = 1'b0;
		send_fct_now = 1'b0;
		tx_write = 1'b0;
		tx_data = '0;
		reset_credit_and_nulls();
		data_order();
		fct_batching();
		fct_saturation();
		line_coding();
		dropped_write();
		total_errs = mismatch_errs + line_errs + other_errs;
		$display("Errors: %0d mismatch, %0d line coding, %0d other",
			mismatch_errs, line_errs, other_errs);
		if (total_errs == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
